//--- common/analog_pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////
// Analog data path constants
//////////////////////////////////////////////////////////////

package analog_pkg;

  // ADC pin word
  localparam int unsigned ADC_RAW_W = 16;  // Raw word from the ADC pins
  localparam int unsigned ADC_RSV_W = 2;   // Reserved low bits, always dropped

  // Sample width on both acquisition and generation sides
  // Also the width of one DAC code
  localparam int unsigned SMP_W = 14;

  // One guard bit for the sum of two samples
  localparam int unsigned SUM_W = SMP_W + 1;

  //////////////////////////////////////////////////////////////
  // Saturation limits
  //////////////////////////////////////////////////////////////

  // Largest positive sample, +8191
  localparam logic signed [SMP_W-1:0] SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};

  // Most negative sample, -8192
  localparam logic signed [SMP_W-1:0] SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};

  // Notes on the codes used at the pins
  //
  // ADC and DAC both use a negative-slope offset code
  // Top bit kept, lower bits inverted, on either side
  // A raw ADC zero word therefore reads back as SMP_MAX
  //
  // Two top sum bits that differ mean the sum left the
  // SMP_W range; sum top bit gives the direction
  //
  // Widths chain together as
  //   ADC_RAW_W - ADC_RSV_W == SMP_W
  //   SMP_W + 1             == SUM_W
  //
  // No types live here; ports use these widths directly

endpackage

`default_nettype wire

//--- adc/adc_frontend.sv
`default_nettype none
`timescale 1ns/1ps

// ADC front end with capture, reserved-bit removal, code conversion and loopback
module adc_frontend (
  input  wire                                   adc_clk,
  input  wire                                   rst_n_i,         // Sync, active low
  // Raw ADC words from the pins
  input  wire         [analog_pkg::ADC_RAW_W-1:0] adc_dat_a_i,
  input  wire         [analog_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  // Loopback control and samples from the DAC side
  input  wire                                   digital_loop_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     loop_a_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     loop_b_i,
  // Two's-complement samples out
  output logic signed [analog_pkg::SMP_W-1:0]     smp_a_o,
  output logic signed [analog_pkg::SMP_W-1:0]     smp_b_o
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////
  // Capture register
  //////////////////////////////////////////////////////////////

  logic [SMP_W-1:0] raw_a_q;  // Upper bits of channel A word
  logic [SMP_W-1:0] raw_b_q;  // Upper bits of channel B word

  // Sits next to the pins in the IO block
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= '0;  // Zero word reads as +8191
      raw_b_q <= '0;
    end
    else
    begin
      // Two reserved low bits dropped here
      raw_a_q <= adc_dat_a_i[ADC_RAW_W-1:ADC_RSV_W];
      raw_b_q <= adc_dat_b_i[ADC_RAW_W-1:ADC_RSV_W];
    end
  end

  //////////////////////////////////////////////////////////////
  // Negative slope to two's complement
  //////////////////////////////////////////////////////////////

  // Keep sign position, flip magnitude bits
  function automatic logic signed [SMP_W-1:0] neg_to_twos_f(
    input logic [SMP_W-1:0] code
  );
    return {code[SMP_W-1], ~code[SMP_W-2:0]};
  endfunction

  logic signed [SMP_W-1:0] conv_a;
  logic signed [SMP_W-1:0] conv_b;

  assign conv_a = neg_to_twos_f(raw_a_q);
  assign conv_b = neg_to_twos_f(raw_b_q);

  // Loopback select, combinational on the control level
  // Loop samples come straight from the mixer saturation
  assign smp_a_o = digital_loop_i ? loop_a_i : conv_a;
  assign smp_b_o = digital_loop_i ? loop_b_i : conv_b;

  //////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////

  // An X on the loop control would corrupt both sample streams
  // and also the external consumer fed from them
  a_loop_known: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown(digital_loop_i)
  )
  else
    $error("digital_loop_i unknown out of reset");

endmodule

`default_nettype wire

//--- dac/dac_mixer.sv
`default_nettype none
`timescale 1ns/1ps

// Generator plus controller sum, saturation and DAC output register
module dac_mixer (
  input  wire                                   adc_clk,
  input  wire                                   rst_n_i,      // Sync, active low
  // Generator samples
  input  wire  signed [analog_pkg::SMP_W-1:0]     asg_dat_a_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     asg_dat_b_i,
  // Controller samples
  input  wire  signed [analog_pkg::SMP_W-1:0]     pid_dat_a_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     pid_dat_b_i,
  // Saturated samples, unregistered, for loopback
  output logic signed [analog_pkg::SMP_W-1:0]     sat_a_o,
  output logic signed [analog_pkg::SMP_W-1:0]     sat_b_o,
  // Negative-slope DAC codes to the pins
  output logic        [analog_pkg::SMP_W-1:0]     dac_dat_a_o,
  output logic        [analog_pkg::SMP_W-1:0]     dac_dat_b_o
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////
  // Sum with one guard bit
  //////////////////////////////////////////////////////////////

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;

  // Explicit sign extension of both operands
  assign sum_a = {asg_dat_a_i[SMP_W-1], asg_dat_a_i} + {pid_dat_a_i[SMP_W-1], pid_dat_a_i};
  assign sum_b = {asg_dat_b_i[SMP_W-1], asg_dat_b_i} + {pid_dat_b_i[SMP_W-1], pid_dat_b_i};

  //////////////////////////////////////////////////////////////
  // Saturation
  //////////////////////////////////////////////////////////////

  // Top two bits differ means overflow, top bit gives direction
  function automatic logic signed [SMP_W-1:0] sat_f(
    input logic [SUM_W-1:0] s
  );
    logic signed [SMP_W-1:0] res;
    if (s[SUM_W-1] != s[SUM_W-2])
    begin
      res = s[SUM_W-1] ? SMP_MIN : SMP_MAX;  // Clip to rail
    end
    else
    begin
      res = s[SMP_W-1:0];  // In range, drop guard bit
    end
    return res;
  endfunction

  assign sat_a_o = sat_f(sum_a);
  assign sat_b_o = sat_f(sum_b);

  //////////////////////////////////////////////////////////////
  // DAC output register
  //////////////////////////////////////////////////////////////

  // Signed to negative-slope offset code
  function automatic logic [SMP_W-1:0] dac_code_f(
    input logic signed [SMP_W-1:0] smp
  );
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= '0;  // Same as output primitive reset
      dac_dat_b_o <= '0;
    end
    else
    begin
      dac_dat_a_o <= dac_code_f(sat_a_o);
      dac_dat_b_o <= dac_code_f(sat_b_o);
    end
  end

  //////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////

  // Pins must idle at zero right after a reset cycle
  a_dac_rst_zero: assert property (
    @(posedge adc_clk)
    !rst_n_i |=> (dac_dat_a_o == '0) && (dac_dat_b_o == '0)
  )
  else
    $error("DAC outputs not zero after reset");

  // Overflow needs two operands of one sign
  // Generator sign then picks the rail
  a_sat_a_rail: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (sum_a[SUM_W-1] != sum_a[SUM_W-2]) |->
      (sat_a_o == (asg_dat_a_i[SMP_W-1] ? SMP_MIN : SMP_MAX))
  )
  else
    $error("Channel A saturation off rail");

  a_sat_b_rail: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (sum_b[SUM_W-1] != sum_b[SUM_W-2]) |->
      (sat_b_o == (asg_dat_b_i[SMP_W-1] ? SMP_MIN : SMP_MAX))
  )
  else
    $error("Channel B saturation off rail");

endmodule

`default_nettype wire

//--- hw/analog_top.sv
`default_nettype none
`timescale 1ns/1ps

// Analog data path top, single adc_clk domain
module analog_top (
  input  wire                                   adc_clk,
  input  wire                                   rst_n_i,         // Sync, active low
  // ADC pins
  input  wire         [analog_pkg::ADC_RAW_W-1:0] adc_dat_a_i,
  input  wire         [analog_pkg::ADC_RAW_W-1:0] adc_dat_b_i,
  // Loopback control
  input  wire                                   digital_loop_i,
  // Generator and controller streams
  input  wire  signed [analog_pkg::SMP_W-1:0]     asg_dat_a_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     asg_dat_b_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     pid_dat_a_i,
  input  wire  signed [analog_pkg::SMP_W-1:0]     pid_dat_b_i,
  // Acquired samples, to scope or controller
  output logic signed [analog_pkg::SMP_W-1:0]     adc_smp_a_o,
  output logic signed [analog_pkg::SMP_W-1:0]     adc_smp_b_o,
  // DAC pins, both channels in parallel
  output logic        [analog_pkg::SMP_W-1:0]     dac_dat_a_o,
  output logic        [analog_pkg::SMP_W-1:0]     dac_dat_b_o
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////
  // Loopback path
  //////////////////////////////////////////////////////////////

  // Saturated mixer samples, fed back to the front end
  logic signed [SMP_W-1:0] sat_a;
  logic signed [SMP_W-1:0] sat_b;

  //////////////////////////////////////////////////////////////
  // Acquisition
  //////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),  // Only user of the control
    .loop_a_i       (sat_a),           // Loopback A
    .loop_b_i       (sat_b),           // Loopback B
    .smp_a_o        (adc_smp_a_o),
    .smp_b_o        (adc_smp_b_o)
  );

  //////////////////////////////////////////////////////////////
  // Generation
  //////////////////////////////////////////////////////////////

  dac_mixer u_dac_mixer (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .asg_dat_a_i (asg_dat_a_i),
    .asg_dat_b_i (asg_dat_b_i),
    .pid_dat_a_i (pid_dat_a_i),
    .pid_dat_b_i (pid_dat_b_i),
    .sat_a_o     (sat_a),        // Combinational, same cycle
    .sat_b_o     (sat_b),
    .dac_dat_a_o (dac_dat_a_o),  // Registered, 1 cycle
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

//--- dv/analog_tb.sv
`default_nettype none
`timescale 1ns/1ps

module analog_tb;

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////
  // Run length
  //////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD_NS = 8;
  localparam int RST_CYCLES    = 8;
  localparam int N_SETTLE      = 3;    // Idle cycles right after reset
  localparam int N_RANDOM      = 500;  // Per random test
  localparam int N_DIR         = 8;    // Directed saturation pairs
  localparam int N_LOOP        = 200;
  localparam int N_EXIT        = 10;   // Back on the ADC after loopback
  localparam int N_TAIL        = 2;    // Drains the last registered check
  localparam int STIM_CYCLES   = N_SETTLE + 3 * N_RANDOM + N_DIR + N_LOOP + N_EXIT + N_TAIL;
  localparam int MARGIN_CYCLES = 100;
  localparam int TIMEOUT_NS    = (STIM_CYCLES + RST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

  // DUT side
  logic                    adc_clk = 1'b0;
  logic                    rst_n_i;
  logic [ADC_RAW_W-1:0]    adc_dat_a_i;
  logic [ADC_RAW_W-1:0]    adc_dat_b_i;
  logic                    digital_loop_i;
  logic signed [SMP_W-1:0] asg_dat_a_i;
  logic signed [SMP_W-1:0] asg_dat_b_i;
  logic signed [SMP_W-1:0] pid_dat_a_i;
  logic signed [SMP_W-1:0] pid_dat_b_i;
  logic signed [SMP_W-1:0] adc_smp_a_o;
  logic signed [SMP_W-1:0] adc_smp_b_o;
  logic [SMP_W-1:0]        dac_dat_a_o;
  logic [SMP_W-1:0]        dac_dat_b_o;

  int    seed = 8;
  int    err_smp = 0;
  int    err_dac = 0;
  string test_name;

  // Inputs seen one cycle back, for the registered outputs
  bit                      have_prev = 1'b0;
  logic                    prev_rst;
  logic [ADC_RAW_W-1:0]    prev_raw_a;
  logic [ADC_RAW_W-1:0]    prev_raw_b;
  logic signed [SMP_W-1:0] prev_asg_a;
  logic signed [SMP_W-1:0] prev_asg_b;
  logic signed [SMP_W-1:0] prev_pid_a;
  logic signed [SMP_W-1:0] prev_pid_b;
  string                   prev_name;

  logic signed [SMP_W-1:0] exp_smp_a;
  logic signed [SMP_W-1:0] exp_smp_b;
  logic [SMP_W-1:0]        exp_dac_a;
  logic [SMP_W-1:0]        exp_dac_b;
  string                   smp_name;

  always #(CLK_PERIOD_NS / 2) adc_clk = ~adc_clk;

  analog_top u_dut (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop_i),
    .asg_dat_a_i    (asg_dat_a_i),
    .asg_dat_b_i    (asg_dat_b_i),
    .pid_dat_a_i    (pid_dat_a_i),
    .pid_dat_b_i    (pid_dat_b_i),
    .adc_smp_a_o    (adc_smp_a_o),
    .adc_smp_b_o    (adc_smp_b_o),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  //////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////

  // Negative slope code means value = 8191 - code over the full range
  function automatic logic signed [SMP_W-1:0] adc_ref(input logic [ADC_RAW_W-1:0] raw);
    int v;
    v = int'(SMP_MAX) - int'(raw[ADC_RAW_W-1:ADC_RSV_W]);  // Reserved bits ignored
    return v[SMP_W-1:0];
  endfunction

  function automatic logic signed [SMP_W-1:0] sat_ref(
    input logic signed [SMP_W-1:0] a,
    input logic signed [SMP_W-1:0] b
  );
    int s;
    s = int'(a) + int'(b);
    if (s > int'(SMP_MAX))
      return SMP_MAX;
    else if (s < int'(SMP_MIN))
      return SMP_MIN;
    return s[SMP_W-1:0];
  endfunction

  // Same offset relation on the DAC side
  function automatic logic [SMP_W-1:0] dac_ref(input logic signed [SMP_W-1:0] smp);
    int code;
    code = int'(SMP_MAX) - int'(smp);
    return code[SMP_W-1:0];
  endfunction

  //////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////

  task automatic check_smp(input string name, input string sig,
                           input logic signed [SMP_W-1:0] exp,
                           input logic signed [SMP_W-1:0] act);
    if (act !== exp)
    begin
      err_smp++;
      $display("[ERROR] %s %s: expected %0d, actual %0d", name, sig, exp, act);
    end
  endtask

  task automatic check_dac(input string name, input string sig,
                           input logic [SMP_W-1:0] exp,
                           input logic [SMP_W-1:0] act);
    if (act !== exp)
    begin
      err_dac++;
      $display("[ERROR] %s %s: expected 0x%h, actual 0x%h", name, sig, exp, act);
    end
  endtask

  // Mid-cycle compare, outputs settled since the rising edge
  always @(negedge adc_clk)
  begin
    if (have_prev)
    begin
      if (!prev_rst)
      begin
        exp_smp_a = SMP_MAX;  // Zero capture word
        exp_smp_b = SMP_MAX;
        exp_dac_a = '0;
        exp_dac_b = '0;
      end
      else
      begin
        exp_smp_a = adc_ref(prev_raw_a);
        exp_smp_b = adc_ref(prev_raw_b);
        exp_dac_a = dac_ref(sat_ref(prev_asg_a, prev_pid_a));
        exp_dac_b = dac_ref(sat_ref(prev_asg_b, prev_pid_b));
      end
      smp_name = prev_name;
      if (digital_loop_i)
      begin
        exp_smp_a = sat_ref(asg_dat_a_i, pid_dat_a_i);  // Same cycle
        exp_smp_b = sat_ref(asg_dat_b_i, pid_dat_b_i);
        smp_name  = test_name;
      end
      check_smp(smp_name, "adc_smp_a_o", exp_smp_a, adc_smp_a_o);
      check_smp(smp_name, "adc_smp_b_o", exp_smp_b, adc_smp_b_o);
      check_dac(prev_name, "dac_dat_a_o", exp_dac_a, dac_dat_a_o);
      check_dac(prev_name, "dac_dat_b_o", exp_dac_b, dac_dat_b_o);
    end
    prev_rst   = rst_n_i;
    prev_raw_a = adc_dat_a_i;
    prev_raw_b = adc_dat_b_i;
    prev_asg_a = asg_dat_a_i;
    prev_asg_b = asg_dat_b_i;
    prev_pid_a = pid_dat_a_i;
    prev_pid_b = pid_dat_b_i;
    prev_name  = test_name;
    have_prev  = 1'b1;
  end

  //////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////

  function automatic logic [ADC_RAW_W-1:0] rand_raw();
    logic [31:0] r;
    r = $random(seed);
    return r[ADC_RAW_W-1:0];
  endfunction

  function automatic logic signed [SMP_W-1:0] rand_smp();
    logic [31:0] r;
    r = $random(seed);
    return r[SMP_W-1:0];
  endfunction

  // Half range, two of these never overflow
  function automatic logic signed [SMP_W-1:0] rand_small();
    logic [31:0] r;
    r = $random(seed);
    return {r[SMP_W-2], r[SMP_W-2:0]};
  endfunction

  task automatic drive_cycle(
    input string                   name,
    input logic                    loop,
    input logic [ADC_RAW_W-1:0]    raw_a,
    input logic [ADC_RAW_W-1:0]    raw_b,
    input logic signed [SMP_W-1:0] ga,
    input logic signed [SMP_W-1:0] pa,
    input logic signed [SMP_W-1:0] gb,
    input logic signed [SMP_W-1:0] pb
  );
    @(posedge adc_clk);
    test_name      <= name;
    digital_loop_i <= loop;
    adc_dat_a_i    <= raw_a;
    adc_dat_b_i    <= raw_b;
    asg_dat_a_i    <= ga;
    pid_dat_a_i    <= pa;
    asg_dat_b_i    <= gb;
    pid_dat_b_i    <= pb;
  endtask

  task automatic drive_sat_pair(input logic signed [SMP_W-1:0] g,
                                input logic signed [SMP_W-1:0] p);
    drive_cycle("sat_directed", 1'b0, '0, '0, g, p, p, g);  // B gets the pair swapped
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////

  initial
  begin
    test_name      = "reset";
    rst_n_i        = 1'b0;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    digital_loop_i = 1'b0;
    asg_dat_a_i    = '0;
    asg_dat_b_i    = '0;
    pid_dat_a_i    = '0;
    pid_dat_b_i    = '0;

    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    for (int i = 0; i < N_SETTLE; i++)
      drive_cycle("reset", 1'b0, '0, '0, '0, '0, '0, '0);

    for (int i = 0; i < N_RANDOM; i++)  // Reserved bits random too
      drive_cycle("adc_conv", 1'b0, rand_raw(), rand_raw(), '0, '0, '0, '0);

    for (int i = 0; i < N_RANDOM; i++)
      drive_cycle("dac_sum", 1'b0, '0, '0, rand_small(), rand_small(), rand_small(),
                  rand_small());

    // Rails and just past them
    drive_sat_pair(SMP_MAX, SMP_MAX);
    drive_sat_pair(SMP_MIN, SMP_MIN);
    drive_sat_pair(SMP_MAX, 14'sd1);
    drive_sat_pair(SMP_MIN, -14'sd1);
    drive_sat_pair(SMP_MAX, 14'sd0);
    drive_sat_pair(SMP_MIN, 14'sd0);
    drive_sat_pair(14'sd8190, 14'sd1);  // Lands exactly on the top
    drive_sat_pair(SMP_MAX, SMP_MIN);

    for (int i = 0; i < N_RANDOM; i++)
      drive_cycle("sat_random", 1'b0, '0, '0, rand_smp(), rand_smp(), rand_smp(), rand_smp());

    // ADC words keep moving, must not leak through
    for (int i = 0; i < N_LOOP; i++)
      drive_cycle("loopback", 1'b1, rand_raw(), rand_raw(), rand_smp(), rand_smp(),
                  rand_smp(), rand_smp());

    for (int i = 0; i < N_EXIT; i++)
      drive_cycle("loop_exit", 1'b0, rand_raw(), rand_raw(), '0, '0, '0, '0);

    repeat (N_TAIL) @(posedge adc_clk);
    $display("Error counts: %0d sample, %0d DAC, %0d total", err_smp, err_dac,
             err_smp + err_dac);
    if (err_smp + err_dac == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not finish in %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the analog data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=analog_tb

# Compile to a binary
verilator --binary --timing --assert \
  -f analog_io.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run the simulation into the log
"$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench reported a clean run
if grep -q "^Finished with no errors$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- analog_io.f
common/analog_pkg.sv
adc/adc_frontend.sv
dac/dac_mixer.sv
hw/analog_top.sv
dv/analog_tb.sv
